/* hw/div_pkg.sv */
//**************************************************
// Divide unit shared definitions
// Operand and result widths, core FSM states and
// the fixed number of restoring steps
//**************************************************

package div_pkg;

    // Operand widths of the 16 by 8 divide
    typedef logic [15:0] dividend_t;
    typedef logic [7:0]  divisor_t;

    // Result widths, remainder is always a magnitude
    typedef logic [7:0]  quot_t;
    typedef logic [7:0]  rem_t;

    // Core FSM
    typedef enum logic [1:0] {
        st_idle,   // Waiting for a request and a free result slot
        st_run,    // Shift and subtract iterations
        st_write   // Result handed to the output side
    } div_state_t;

    // One iteration per dividend bit
    localparam int DIV_STEPS = 16;

endpackage

/* hw/div_req_queue.sv */
//**************************************************
// Divide request queue
// Credit based FIFO for incoming divide requests,
// one credit goes back per entry popped
//**************************************************

`timescale 1ns/1ns

module div_req_queue import div_pkg::*; #(
    parameter int REQ_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  dividend_t req_dividend,
    input  divisor_t  req_divisor,
    input  logic      req_len,
    input  logic      req_sign,
    input  logic      q_pop,
    output logic      req_credit,
    output logic      q_valid,
    output dividend_t q_dividend,
    output divisor_t  q_divisor,
    output logic      q_len,
    output logic      q_sign
);

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    // Entry storage
    dividend_t mem_dividend [REQ_DEPTH];
    divisor_t  mem_divisor  [REQ_DEPTH];
    logic      mem_len      [REQ_DEPTH];
    logic      mem_sign     [REQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Requester only pushes while holding a credit
    assign q_valid    = (count != '0);

    // Head entry seen by the core
    assign q_dividend = mem_dividend[rd_ptr];
    assign q_divisor  = mem_divisor[rd_ptr];
    assign q_len      = mem_len[rd_ptr];
    assign q_sign     = mem_sign[rd_ptr];

    // Write side, no reset on the payload
    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem_dividend[wr_ptr] <= req_dividend;
            mem_divisor[wr_ptr]  <= req_divisor;
            mem_len[wr_ptr]      <= req_len;
            mem_sign[wr_ptr]     <= req_sign;
        end
    end

    //**************************************************
    // Pointers, occupancy and credit return
    //**************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            // Credit goes back together with the head update
            req_credit <= q_pop;
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A push into a full queue means the requester lost track of its credits
    assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (count < CNT_W'(REQ_DEPTH)));

endmodule

/* hw/div_core.sv */
//**************************************************
// Restoring divider core
// Signed or unsigned 16 by 8 divide in 16 steps,
// with quotient sign fix and overflow detection
//**************************************************

`timescale 1ns/1ns

module div_core import div_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      q_valid,
    input  dividend_t q_dividend,
    input  divisor_t  q_divisor,
    input  logic      q_len,
    input  logic      q_sign,
    input  logic      res_room,
    output logic      q_pop,
    output logic      div_done,
    output quot_t     div_quot,
    output rem_t      div_rem,
    output logic      div_v
);

    localparam int STEP_W = $clog2(DIV_STEPS);

    div_state_t        state;
    logic [STEP_W-1:0] step;

    // Operand magnitudes from the queue head
    dividend_t dvd_ext;
    dividend_t dvd_mag;
    divisor_t  dsr_mag;
    logic      dvd_neg;
    logic      dsr_neg;

    // Iteration registers
    rem_t        part;      // Partial remainder, always below the divisor
    dividend_t   dvd;       // Dividend bits still to shift in
    divisor_t    divor;
    logic [15:0] quo;       // Full magnitude quotient
    logic        neg_q;
    logic        zero_div;

    // One restoring step
    logic [8:0] shifted;
    rem_t       diff;
    logic       fits;

    //**************************************************
    // Operand preparation
    //**************************************************
    always_comb begin
        // Short dividend only uses the low byte
        if (q_len) begin
            dvd_ext = q_dividend;
        end else if (q_sign) begin
            dvd_ext = {{8{q_dividend[7]}}, q_dividend[7:0]};
        end else begin
            dvd_ext = {8'd0, q_dividend[7:0]};
        end
        dvd_neg = q_sign & dvd_ext[15];
        dsr_neg = q_sign & q_divisor[7];
        // Two's complement magnitudes, -32768 and -128 map to their unsigned values
        dvd_mag = dvd_neg ? ~dvd_ext + 16'd1 : dvd_ext;
        dsr_mag = dsr_neg ? ~q_divisor + 8'd1 : q_divisor;
    end

    // Shift next dividend bit in, subtract when the divisor fits
    assign shifted = {part, dvd[15]};
    assign diff    = shifted[7:0] - divor;
    assign fits    = (shifted >= {1'b0, divor});

    // Start only when a result slot is guaranteed for this operation
    assign q_pop    = (state == st_idle) && q_valid && res_room;
    assign div_done = (state == st_write);

    // Result valid in the write state
    assign div_quot = neg_q ? ~quo[7:0] + 8'd1 : quo[7:0];
    assign div_rem  = part;
    assign div_v    = zero_div | (quo[15:8] != 8'd0);

    //**************************************************
    // FSM and step counter
    //**************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    step <= '0;
                    if (q_pop) state <= st_run;
                end
                st_run: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(DIV_STEPS - 1)) state <= st_write;
                end
                st_write: state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (q_pop) begin
            part     <= '0;
            dvd      <= dvd_mag;
            divor    <= dsr_mag;
            quo      <= '0;
            neg_q    <= dvd_neg ^ dsr_neg;
            zero_div <= (q_divisor == 8'd0);
        end else if (state == st_run) begin
            part <= fits ? diff : shifted[7:0];
            dvd  <= {dvd[14:0], 1'b0};
            quo  <= {quo[14:0], fits};
        end
    end

    // Every accepted request produces its result a fixed time later
    assert property (@(posedge clk) disable iff (rst)
        q_pop |-> q_valid ##(DIV_STEPS + 1) div_done);

endmodule

/* hw/div_result_port.sv */
//**************************************************
// Divide result port
// Result FIFO released to the consumer only while
// downstream credits remain
//**************************************************

`timescale 1ns/1ns

module div_result_port import div_pkg::*; #(
    parameter int RES_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  div_done,
    input  quot_t div_quot,
    input  rem_t  div_rem,
    input  logic  div_v,
    input  logic  res_credit,
    output logic  res_room,
    output logic  res_valid,
    output quot_t res_quot,
    output rem_t  res_rem,
    output logic  res_v
);

    localparam int PTR_W = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
    localparam int CNT_W = $clog2(RES_DEPTH + 1);
    // One spare code so an extra credit is visible
    localparam int CRD_W = $clog2(OUT_CREDITS + 2);

    // Result storage
    quot_t mem_quot [RES_DEPTH];
    rem_t  mem_rem  [RES_DEPTH];
    logic  mem_v    [RES_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;
    logic             send;

    // Free slot seen by the core before it starts
    assign res_room = (count < CNT_W'(RES_DEPTH));
    assign send     = (count != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (div_done) begin
            mem_quot[wr_ptr] <= div_quot;
            mem_rem[wr_ptr]  <= div_rem;
            mem_v[wr_ptr]    <= div_v;
        end
        // Output payload follows the head on each send
        if (send) begin
            res_quot <= mem_quot[rd_ptr];
            res_rem  <= mem_rem[rd_ptr];
            res_v    <= mem_v[rd_ptr];
        end
    end

    //**************************************************
    // Pointers, occupancy and downstream credits
    //**************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= CRD_W'(OUT_CREDITS);
            res_valid <= 1'b0;
        end else begin
            res_valid <= send;
            if (div_done) begin
                wr_ptr <= (wr_ptr == PTR_W'(RES_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_W'(RES_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({div_done, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Returned credit and a send in the same cycle cancel out
            case ({res_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Consumer never returns more credits than it was given
    assert property (@(posedge clk) disable iff (rst)
        credits <= CRD_W'(OUT_CREDITS));

endmodule

/* hw/div_unit_top.sv */
//**************************************************
// Divide unit top level
// Request queue, divider core and result port
//**************************************************

`timescale 1ns/1ns

module div_unit_top import div_pkg::*; #(
    parameter int REQ_DEPTH   = 4,
    parameter int RES_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic      clk,
    input  logic      rst,
    // Requester side
    input  logic      req_valid,
    input  dividend_t req_dividend,
    input  divisor_t  req_divisor,
    input  logic      req_len,
    input  logic      req_sign,
    output logic      req_credit,
    // Consumer side
    output logic      res_valid,
    output quot_t     res_quot,
    output rem_t      res_rem,
    output logic      res_v,
    input  logic      res_credit
);

    // Queue head towards the core
    logic      q_valid;
    logic      q_pop;
    dividend_t q_dividend;
    divisor_t  q_divisor;
    logic      q_len;
    logic      q_sign;

    // Core results towards the output side
    logic      div_done;
    quot_t     div_quot;
    rem_t      div_rem;
    logic      div_v;
    logic      res_room;

    div_req_queue #(
        .REQ_DEPTH    (REQ_DEPTH)
    ) u_req_queue (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_dividend (req_dividend),
        .req_divisor  (req_divisor),
        .req_len      (req_len),
        .req_sign     (req_sign),
        .q_pop        (q_pop),
        .req_credit   (req_credit),
        .q_valid      (q_valid),
        .q_dividend   (q_dividend),
        .q_divisor    (q_divisor),
        .q_len        (q_len),
        .q_sign       (q_sign)
    );

    // Single operation in flight
    div_core u_core (
        .clk          (clk),
        .rst          (rst),
        .q_valid      (q_valid),
        .q_dividend   (q_dividend),
        .q_divisor    (q_divisor),
        .q_len        (q_len),
        .q_sign       (q_sign),
        .res_room     (res_room),
        .q_pop        (q_pop),
        .div_done     (div_done),
        .div_quot     (div_quot),
        .div_rem      (div_rem),
        .div_v        (div_v)
    );

    div_result_port #(
        .RES_DEPTH    (RES_DEPTH),
        .OUT_CREDITS  (OUT_CREDITS)
    ) u_result_port (
        .clk          (clk),
        .rst          (rst),
        .div_done     (div_done),
        .div_quot     (div_quot),
        .div_rem      (div_rem),
        .div_v        (div_v),
        .res_credit   (res_credit),
        .res_room     (res_room),
        .res_valid    (res_valid),
        .res_quot     (res_quot),
        .res_rem      (res_rem),
        .res_v        (res_v)
    );

endmodule

/* sim/div_unit_tb.sv */
//**************************************************
// Divide unit testbench
// Credit based requester and consumer around the
// divide unit, results checked in request order
//**************************************************

`timescale 1ns/1ns

module div_unit_tb import div_pkg::*; ;

    localparam int NUM_VEC     = 23;
    localparam int FIELDS      = 7;
    localparam int REQ_DEPTH   = 4;
    localparam int OUT_CREDITS = 2;
    localparam int CLK_NS      = 8;
    localparam int TIMEOUT_NS  = (NUM_VEC * 40 + 2000) * CLK_NS;

    logic      clk = 1'b0;
    logic      rst;
    logic      req_valid;
    dividend_t req_dividend;
    divisor_t  req_divisor;
    logic      req_len;
    logic      req_sign;
    logic      req_credit;
    logic      res_valid;
    quot_t     res_quot;
    rem_t      res_rem;
    logic      res_v;
    logic      res_credit;

    // Seven words per operation, in file column order
    logic [15:0] vec_mem [NUM_VEC * FIELDS];

    // Credit bookkeeping on both sides
    int req_sent;
    int req_credits_back;
    int results_seen;
    int res_credits_given;

    div_unit_top UUT (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_dividend (req_dividend),
        .req_divisor  (req_divisor),
        .req_len      (req_len),
        .req_sign     (req_sign),
        .req_credit   (req_credit),
        .res_valid    (res_valid),
        .res_quot     (res_quot),
        .res_rem      (res_rem),
        .res_v        (res_v),
        .res_credit   (res_credit)
    );

    always #(CLK_NS / 2) clk = ~clk;

    //**************************************************
    // Checking helpers
    //**************************************************
    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h expected %h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic stop_on_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // Quotient and remainder are undefined for a zero divisor
    task automatic check_result(input int idx);
        int base;
        base = idx * FIELDS;
        check_value("res_v", {15'd0, res_v}, vec_mem[base + 6]);
        if (!(vec_mem[base + 6][0] && vec_mem[base + 1] == 16'd0)) begin
            check_value("res_quot", {8'd0, res_quot}, vec_mem[base + 4]);
            check_value("res_rem", {8'd0, res_rem}, vec_mem[base + 5]);
        end
    endtask

    //**************************************************
    // Requester and consumer
    //**************************************************
    // First eight requests go out as fast as credits allow
    task automatic send_requests();
        int gap;
        for (int i = 0; i < NUM_VEC; i++) begin
            gap = (i < 8) ? 0 : $urandom_range(0, 6);
            repeat (gap) begin
                @(negedge clk);
                req_valid = 1'b0;
            end
            @(negedge clk);
            while (REQ_DEPTH + req_credits_back - req_sent <= 0) begin
                req_valid = 1'b0;
                @(negedge clk);
            end
            req_dividend = vec_mem[i * FIELDS];
            req_divisor  = vec_mem[i * FIELDS + 1][7:0];
            req_len      = vec_mem[i * FIELDS + 2][0];
            req_sign     = vec_mem[i * FIELDS + 3][0];
            req_valid    = 1'b1;
            req_sent++;
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // One credit back per result, now and then after a long hold
    task automatic return_credits();
        int delay;
        forever begin
            @(negedge clk);
            if (results_seen > res_credits_given) begin
                delay = $urandom_range(0, 20);
                if ($urandom_range(0, 5) == 0) delay += $urandom_range(40, 80);
                repeat (delay) @(negedge clk);
                res_credit = 1'b1;
                res_credits_given++;
                @(negedge clk);
                res_credit = 1'b0;
            end
        end
    endtask

    // Outputs sampled on the rising edge, before the DUT updates them
    always @(posedge clk) begin
        if (!rst) begin
            if (req_credit) begin
                req_credits_back++;
                if (req_credits_back > req_sent)
                    stop_on_error("req_credit returned a credit for a request never sent");
            end
            if (res_valid) begin
                if (results_seen >= NUM_VEC)
                    stop_on_error("res_valid pulsed after the last expected result");
                check_result(results_seen);
                results_seen++;
                if (results_seen > res_credits_given + OUT_CREDITS)
                    stop_on_error("more results sent than downstream credits granted");
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        stop_on_error($sformatf("timeout, results stopped arriving after %0d of %0d",
                                results_seen, NUM_VEC));
    end

    //**************************************************
    // Main sequence
    //**************************************************
    initial begin
        void'($urandom(31042));
        rst               = 1'b1;
        req_valid         = 1'b0;
        req_dividend      = '0;
        req_divisor       = '0;
        req_len           = 1'b0;
        req_sign          = 1'b0;
        res_credit        = 1'b0;
        req_sent          = 0;
        req_credits_back  = 0;
        results_seen      = 0;
        res_credits_given = 0;
        $readmemh("sim/div_vectors.txt", vec_mem);
        if (^vec_mem[NUM_VEC * FIELDS - 1] === 1'bx)
            stop_on_error("vector file is missing or shorter than expected");
        repeat (3) @(negedge clk);
        rst = 1'b0;
        fork
            send_requests();
            return_credits();
        join_none
        wait (results_seen == NUM_VEC);
        // Quiet period catches duplicate results and late credits
        repeat (30) @(posedge clk);
        if (req_sent == NUM_VEC && req_credits_back == req_sent) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Request credits returned %0d, requests sent %0d",
                     req_credits_back, req_sent);
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule

/* compile.f */
hw/div_pkg.sv
hw/div_req_queue.sv
hw/div_core.sv
hw/div_result_port.sv
hw/div_unit_top.sv
sim/div_unit_tb.sv

/* sim/div_vectors.txt */
// dividend divisor len sign expected_quot expected_rem expected_v (all hex)
// Zero divisor rows only define the overflow flag
1234 12 1 0 02 10 1
7fff ff 1 0 80 7f 0
feff ff 1 0 ff fe 0
0064 07 1 0 0e 02 0
03e8 0a 1 0 64 00 0
ffff 01 1 0 ff 00 1
1234 00 1 0 00 00 1
0005 09 1 0 00 05 0
c350 c8 1 0 fa 00 0
9c40 9c 1 0 00 40 1
03e8 07 1 1 8e 06 0
fc18 07 1 1 72 06 0
03e8 f9 1 1 72 06 0
fc18 f9 1 1 8e 06 0
8000 80 1 1 00 00 1
fed4 03 1 1 9c 00 0
ff00 00 1 1 00 00 1
12f6 03 0 1 fd 01 0
ab80 ff 0 1 80 00 0
0064 f7 0 1 f5 01 0
7f85 0c 0 0 0b 01 0
ff81 81 0 1 01 00 0
0080 00 0 1 00 00 1
